/* mem_pkg.sv */
package mem_pkg;

    // Memory geometry
    localparam int DATA_WIDTH = 32;
    localparam int MEM_BYTES  = 4096;
    localparam int ADDR_WIDTH = $clog2(MEM_BYTES);  // Byte address width

    // Fill engine word counter width
    localparam int FILL_COUNT_WIDTH = 10;

    // Access size, one code per number of low bytes touched
    typedef enum logic [1:0] {
        SIZE_WORD   = 2'd0,  // Four bytes
        SIZE_TRIPLE = 2'd1,  // Low three bytes
        SIZE_HALF   = 2'd2,  // Low two bytes
        SIZE_BYTE   = 2'd3   // Low byte only
    } mem_size_t;

    // Request from a peer to the arbiter and from the arbiter to the memory
    typedef struct packed {
        logic                  we;
        logic                  re;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        mem_size_t             size;
    } mem_req_t;

    // Command from the core to the load/store port
    typedef struct packed {
        logic                  is_store;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] wdata;
        mem_size_t             size;
        logic                  sign_ext;  // Loads only
    } lsu_cmd_t;

    // Command to the block fill engine
    typedef struct packed {
        logic [ADDR_WIDTH-1:0]       base_addr;
        logic [FILL_COUNT_WIDTH-1:0] word_count;
        logic [DATA_WIDTH-1:0]       pattern;
    } fill_cmd_t;

    // Lane enables for an access of the given size
    function automatic logic [3:0] size_to_byte_en(input mem_size_t size);
        logic [3:0] byte_en;
        case (size)
            SIZE_WORD:   byte_en = 4'b1111;
            SIZE_TRIPLE: byte_en = 4'b0111;
            SIZE_HALF:   byte_en = 4'b0011;
            default:     byte_en = 4'b0001;
        endcase
        return byte_en;
    endfunction

endpackage

/* data_memory.sv */
`timescale 1ns/10ps

module data_memory (
    input  logic                            clk,
    input  logic                            rst,
    input  mem_pkg::mem_req_t               req,
    output logic [mem_pkg::DATA_WIDTH-1:0]  rdata,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]  debug_addr,
    output logic [mem_pkg::DATA_WIDTH-1:0]  debug_data
);
    import mem_pkg::*;

    // Byte-wide storage, little-endian words
    logic [7:0] mem [MEM_BYTES];

    logic [ADDR_WIDTH-1:0] lane [4];      // Byte addresses of the request
    logic [ADDR_WIDTH-1:0] dbg_lane [4];  // Byte addresses of the debug word
    logic [3:0]            byte_en;
    logic [DATA_WIDTH-1:0] size_mask;
    logic [DATA_WIDTH-1:0] rd_word;
    logic [DATA_WIDTH-1:0] dbg_word;

    // Address of byte k after base, wrapping inside the memory
    function automatic logic [ADDR_WIDTH-1:0] lane_addr(
        input logic [ADDR_WIDTH-1:0] base,
        input int                    k
    );
        return base + ADDR_WIDTH'(k);
    endfunction

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            lane[k]     = lane_addr(req.addr, k);
            dbg_lane[k] = lane_addr(debug_addr, k);
        end
    end

    assign byte_en   = size_to_byte_en(req.size);
    assign size_mask = {{8{byte_en[3]}}, {8{byte_en[2]}}, {8{byte_en[1]}}, {8{byte_en[0]}}};

    // Lowest address holds the least significant byte
    assign rd_word  = {mem[lane[3]], mem[lane[2]], mem[lane[1]], mem[lane[0]]};
    assign dbg_word = {mem[dbg_lane[3]], mem[dbg_lane[2]], mem[dbg_lane[1]], mem[dbg_lane[0]]};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MEM_BYTES; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else begin
            if (req.we) begin
                for (int k = 0; k < 4; k++) begin
                    if (byte_en[k]) begin
                        mem[lane[k]] <= req.wdata[8*k +: 8];  // Only the sized lanes
                    end
                end
            end
            if (req.re) begin
                rdata <= rd_word & size_mask;  // Zero-extended, sign handled upstream
            end
        end
    end

    // Debug port samples a full word every cycle
    always_ff @(posedge clk) begin
        debug_data <= dbg_word;
    end

endmodule

/* mem_arbiter.sv */
`timescale 1ns/10ps

module mem_arbiter (
    input  logic              clk,
    input  logic              rst,
    input  logic              lsu_req_valid,
    input  logic              fill_req_valid,
    input  mem_pkg::mem_req_t lsu_req,
    input  mem_pkg::mem_req_t fill_req,
    output logic              lsu_grant,
    output logic              fill_grant,
    output mem_pkg::mem_req_t mem_req,
    input  logic [31:0]       mem_rdata,
    output logic              lsu_rvalid,
    output logic              fill_rvalid,
    output logic [31:0]       rdata
);

    // High when the fill engine had the last grant, so the core port goes next
    logic fill_last;

    // Round-robin pick, combinational from the request levels
    assign lsu_grant  = lsu_req_valid && (!fill_req_valid || fill_last);
    assign fill_grant = fill_req_valid && (!lsu_req_valid || !fill_last);

    always_comb begin
        mem_req = fill_grant ? fill_req : lsu_req;
        if (!(lsu_grant || fill_grant)) begin
            mem_req.we = 1'b0;  // Idle cycle, memory sees no strobe
            mem_req.re = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_last   <= 1'b1;  // Core port wins the first tie
            lsu_rvalid  <= 1'b0;
            fill_rvalid <= 1'b0;
        end else begin
            if (lsu_grant) begin
                fill_last <= 1'b0;
            end else if (fill_grant) begin
                fill_last <= 1'b1;
            end
            // Tag the returning read with its issuer
            lsu_rvalid  <= lsu_grant && lsu_req.re;
            fill_rvalid <= fill_grant && fill_req.re;
        end
    end

    // Read data is shared, the rvalid pulses tell the peers apart
    assign rdata = mem_rdata;

endmodule

/* load_store_port.sv */
`timescale 1ns/10ps

module load_store_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               lsu_start,
    input  mem_pkg::lsu_cmd_t  lsu_cmd,
    output logic               lsu_done,
    output logic [31:0]        lsu_rdata,
    output logic               req_valid,
    output mem_pkg::mem_req_t  req,
    input  logic               grant,
    input  logic               rvalid,
    input  logic [31:0]        rdata
);
    import mem_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,   // Request held until grant
        ST_LOAD   // Waiting for read data
    } lsu_state_t;

    lsu_state_t            state;
    lsu_cmd_t              cmd;       // Latched command
    logic [DATA_WIDTH-1:0] ext_data;
    logic                  fill_bit;

    // Request is built from the latched command so it stays stable
    assign req_valid = (state == ST_REQ);
    assign req.we    = cmd.is_store;
    assign req.re    = !cmd.is_store;
    assign req.addr  = cmd.addr;
    assign req.wdata = cmd.wdata;
    assign req.size  = cmd.size;

    // Sign extension from the top byte of the access
    always_comb begin
        case (cmd.size)
            SIZE_BYTE: begin
                fill_bit = cmd.sign_ext & rdata[7];
                ext_data = {{24{fill_bit}}, rdata[7:0]};
            end
            SIZE_HALF: begin
                fill_bit = cmd.sign_ext & rdata[15];
                ext_data = {{16{fill_bit}}, rdata[15:0]};
            end
            SIZE_TRIPLE: begin
                fill_bit = cmd.sign_ext & rdata[23];
                ext_data = {{8{fill_bit}}, rdata[23:0]};
            end
            default: begin
                fill_bit = 1'b0;
                ext_data = rdata;  // Word load needs no extension
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            lsu_done <= 1'b0;
        end else begin
            lsu_done <= 1'b0;
            case (state)
                ST_IDLE: if (lsu_start) state <= ST_REQ;
                ST_REQ: begin
                    if (grant) begin
                        if (cmd.is_store) begin
                            lsu_done <= 1'b1;  // Store completes the cycle after grant
                            state    <= ST_IDLE;
                        end else begin
                            state <= ST_LOAD;
                        end
                    end
                end
                ST_LOAD: begin
                    if (rvalid) begin
                        lsu_done <= 1'b1;
                        state    <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && lsu_start) cmd <= lsu_cmd;
        if (state == ST_LOAD && rvalid) lsu_rdata <= ext_data;
    end

endmodule

/* block_fill.sv */
`timescale 1ns/10ps

module block_fill (
    input  logic               clk,
    input  logic               rst,
    input  logic               fill_start,
    input  mem_pkg::fill_cmd_t fill_cmd,
    output logic               fill_busy,
    output logic               fill_done,
    output logic               req_valid,
    input  logic               grant,
    output mem_pkg::mem_req_t  req
);
    import mem_pkg::*;

    logic [ADDR_WIDTH-1:0]       cur_addr;
    logic [DATA_WIDTH-1:0]       cur_pattern;
    logic [FILL_COUNT_WIDTH-1:0] remaining;  // Words still to write

    // Always a word write of the current pattern
    assign req_valid = fill_busy;
    assign req.we    = 1'b1;
    assign req.re    = 1'b0;
    assign req.addr  = cur_addr;
    assign req.wdata = cur_pattern;
    assign req.size  = SIZE_WORD;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fill_busy <= 1'b0;
            fill_done <= 1'b0;
            remaining <= '0;
        end else begin
            fill_done <= 1'b0;
            if (!fill_busy) begin
                if (fill_start) begin
                    remaining <= fill_cmd.word_count;
                    if (fill_cmd.word_count == '0) begin
                        fill_done <= 1'b1;  // Empty region, nothing to write
                    end else begin
                        fill_busy <= 1'b1;
                    end
                end
            end else if (grant) begin
                remaining <= remaining - 1'b1;
                if (remaining == FILL_COUNT_WIDTH'(1)) begin
                    fill_busy <= 1'b0;  // Last word granted
                    fill_done <= 1'b1;
                end
            end
        end
    end

    // Address and pattern step together on every granted write
    always_ff @(posedge clk) begin
        if (!fill_busy && fill_start) begin
            cur_addr    <= fill_cmd.base_addr;
            cur_pattern <= fill_cmd.pattern;
        end else if (fill_busy && grant) begin
            cur_addr    <= cur_addr + ADDR_WIDTH'(4);
            cur_pattern <= cur_pattern + 1'b1;
        end
    end

endmodule

/* mem_subsys_top.sv */
`timescale 1ns/10ps

module mem_subsys_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            lsu_start,
    input  mem_pkg::lsu_cmd_t               lsu_cmd,
    output logic                            lsu_done,
    output logic [31:0]                     lsu_rdata,
    input  logic                            fill_start,
    input  mem_pkg::fill_cmd_t              fill_cmd,
    output logic                            fill_busy,
    output logic                            fill_done,
    input  logic [mem_pkg::ADDR_WIDTH-1:0]  debug_addr,
    output logic [mem_pkg::DATA_WIDTH-1:0]  debug_data
);
    import mem_pkg::*;

    // Peer to arbiter
    logic     lsu_req_valid;
    mem_req_t lsu_req;
    logic     lsu_grant;
    logic     lsu_rvalid;
    logic     fill_req_valid;
    mem_req_t fill_req;
    logic     fill_grant;

    // Arbiter to memory
    mem_req_t              mem_req;
    logic [DATA_WIDTH-1:0] mem_rdata;
    logic [31:0]           arb_rdata;

    load_store_port u_lsu (
        .clk       (clk),
        .rst       (rst),
        .lsu_start (lsu_start),
        .lsu_cmd   (lsu_cmd),
        .lsu_done  (lsu_done),
        .lsu_rdata (lsu_rdata),
        .req_valid (lsu_req_valid),
        .req       (lsu_req),
        .grant     (lsu_grant),
        .rvalid    (lsu_rvalid),
        .rdata     (arb_rdata)
    );

    block_fill u_fill (
        .clk        (clk),
        .rst        (rst),
        .fill_start (fill_start),
        .fill_cmd   (fill_cmd),
        .fill_busy  (fill_busy),
        .fill_done  (fill_done),
        .req_valid  (fill_req_valid),
        .grant      (fill_grant),
        .req        (fill_req)
    );

    mem_arbiter u_arb (
        .clk            (clk),
        .rst            (rst),
        .lsu_req_valid  (lsu_req_valid),
        .fill_req_valid (fill_req_valid),
        .lsu_req        (lsu_req),
        .fill_req       (fill_req),
        .lsu_grant      (lsu_grant),
        .fill_grant     (fill_grant),
        .mem_req        (mem_req),
        .mem_rdata      (mem_rdata),
        .lsu_rvalid     (lsu_rvalid),
        .fill_rvalid    (),            // Fill engine only writes
        .rdata          (arb_rdata)
    );

    data_memory u_mem (
        .clk        (clk),
        .rst        (rst),
        .req        (mem_req),
        .rdata      (mem_rdata),
        .debug_addr (debug_addr),
        .debug_data (debug_data)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* mem_subsys_asserts.sv */
`timescale 1ns/10ps

module mem_subsys_asserts (
    input logic              clk,
    input logic              rst,
    input logic              lsu_req_valid,
    input logic              fill_req_valid,
    input mem_pkg::mem_req_t lsu_req,
    input mem_pkg::mem_req_t fill_req,
    input logic              lsu_grant,
    input logic              fill_grant,
    input mem_pkg::mem_req_t mem_req,
    input logic              lsu_rvalid
);

    // One winner per cycle
    one_grant: assert property (@(posedge clk) disable iff (rst) !(lsu_grant && fill_grant))
        else $error("Both peers granted in the same cycle");

    lsu_grant_req: assert property (@(posedge clk) disable iff (rst) lsu_grant |-> lsu_req_valid)
        else $error("Load/store port granted without a request");

    fill_grant_req: assert property (@(posedge clk) disable iff (rst) fill_grant |-> fill_req_valid)
        else $error("Fill engine granted without a request");

    // A waiting peer keeps its request unchanged
    lsu_req_held: assert property (@(posedge clk) disable iff (rst)
        (lsu_req_valid && !lsu_grant) |=> (lsu_req_valid && $stable(lsu_req)))
        else $error("Load/store request changed before its grant");

    fill_req_held: assert property (@(posedge clk) disable iff (rst)
        (fill_req_valid && !fill_grant) |=> (fill_req_valid && $stable(fill_req)))
        else $error("Fill request changed before its grant");

    // Returning data needs a read strobe that reached the memory for the core port
    lsu_rvalid_read: assert property (@(posedge clk) disable iff (rst)
        lsu_rvalid |-> $past(lsu_grant && mem_req.re && !mem_req.we))
        else $error("Read data returned without a granted read");

endmodule

bind mem_arbiter mem_subsys_asserts u_asserts (.*);

/* mem_subsys_tb.sv */
`timescale 1ns/10ps

module mem_subsys_tb;
    import mem_pkg::*;

    localparam int TIMEOUT = 200;  // Clock cycles allowed per wait

    typedef enum {OP_STORE, OP_LOAD, OP_DEBUG, OP_FILL, OP_FILL_LS} op_t;

    typedef struct {
        string                 name;
        op_t                   op;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;      // Store data or fill pattern
        mem_size_t             size;
        logic                  sx;
        logic [DATA_WIDTH-1:0] expected;  // Word count for fills
    } step_t;

    logic                  clk;
    logic                  rst;
    logic                  lsu_start;
    lsu_cmd_t              lsu_cmd;
    logic                  lsu_done;
    logic [31:0]           lsu_rdata;
    logic                  fill_start;
    fill_cmd_t             fill_cmd;
    logic                  fill_busy;
    logic                  fill_done;
    logic [ADDR_WIDTH-1:0] debug_addr;
    logic [DATA_WIDTH-1:0] debug_data;

    step_t      steps[$];
    logic [7:0] model [MEM_BYTES];  // Byte image the DUT should hold
    logic       fail_reported;
    logic       run_passed;

    tb_clock_gen u_clk (.clk(clk), .rst(rst));

    mem_subsys_top uut (.*);

    task automatic stop_on_error();
        fail_reported = 1'b1;
        $display("Testbench failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %08h, actual %08h", name, expected, actual);
            stop_on_error();
        end
    endtask

    task automatic check_done(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %0b, actual %0b", name, expected, actual);
            stop_on_error();
        end
    endtask

    // Little-endian reference, size code k touches the low 4-k bytes
    function automatic void model_store(logic [ADDR_WIDTH-1:0] addr, logic [31:0] data,
                                        mem_size_t size);
        for (int k = 0; k < 4 - int'(size); k++) begin
            model[addr + ADDR_WIDTH'(k)] = data[8*k +: 8];
        end
    endfunction

    function automatic logic [31:0] model_load(logic [ADDR_WIDTH-1:0] addr, mem_size_t size,
                                               logic sx);
        logic [31:0] val;
        int          n;
        n   = 4 - int'(size);
        val = '0;
        for (int k = 0; k < n; k++) begin
            val[8*k +: 8] = model[addr + ADDR_WIDTH'(k)];
        end
        if (sx && n < 4 && val[8*n-1]) begin
            for (int k = n; k < 4; k++) val[8*k +: 8] = 8'hFF;
        end
        return val;
    endfunction

    task automatic run_lsu(input string name, input logic st, input logic [ADDR_WIDTH-1:0] addr,
                           input logic [31:0] data, input mem_size_t size, input logic sx,
                           output logic [31:0] result);
        int n;
        @(posedge clk);
        lsu_start <= 1'b1;
        lsu_cmd   <= '{is_store: st, addr: addr, wdata: data, size: size, sign_ext: sx};
        @(posedge clk);
        lsu_start <= 1'b0;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (lsu_done) break;
        end
        if (n == TIMEOUT) begin
            $display("Timed out waiting for lsu_done in %s", name);
            stop_on_error();
        end
        result = lsu_rdata;
        if (st) model_store(addr, data, size);
    endtask

    task automatic read_debug(input logic [ADDR_WIDTH-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        debug_addr <= addr;
        @(posedge clk);  // Registered one cycle later
        @(negedge clk);
        data = debug_data;
    endtask

    task automatic start_fill(input step_t s);
        @(posedge clk);
        fill_start <= 1'b1;
        fill_cmd   <= '{base_addr: s.addr, word_count: s.expected[9:0], pattern: s.data};
        @(posedge clk);
        fill_start <= 1'b0;
    endtask

    // Wait for the end of a fill, then compare the region and the word past it
    task automatic finish_fill(input step_t s);
        logic [31:0] got;
        int          n;
        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (fill_done) break;
        end
        if (n == TIMEOUT) begin
            $display("Timed out waiting for fill_done in %s", s.name);
            stop_on_error();
        end
        check_done({s.name, " busy"}, 1'b0, fill_busy);
        for (int i = 0; i < int'(s.expected); i++) begin
            model_store(s.addr + ADDR_WIDTH'(4*i), s.data + i, SIZE_WORD);
        end
        for (int i = 0; i <= int'(s.expected); i++) begin
            read_debug(s.addr + ADDR_WIDTH'(4*i), got);
            check_word($sformatf("%s word %0d", s.name, i), model_load(s.addr + ADDR_WIDTH'(4*i),
                       SIZE_WORD, 1'b0), got);
        end
    endtask

    task automatic add_step(input string name, input op_t op, input logic [ADDR_WIDTH-1:0] addr,
                            input logic [31:0] data, input mem_size_t size, input logic sx,
                            input logic [31:0] expected);
        steps.push_back('{name, op, addr, data, size, sx, expected});
    endtask

    task automatic apply_step(input step_t s);
        logic [31:0] got;
        logic [ADDR_WIDTH-1:0] side;
        side = s.addr ^ ADDR_WIDTH'(12'h800);  // Load/store address away from the fill region
        case (s.op)
            OP_STORE: run_lsu(s.name, 1'b1, s.addr, s.data, s.size, s.sx, got);
            OP_LOAD: begin
                run_lsu(s.name, 1'b0, s.addr, '0, s.size, s.sx, got);
                check_word(s.name, s.expected, got);
            end
            OP_DEBUG: begin
                read_debug(s.addr, got);
                check_word(s.name, s.expected, got);
            end
            OP_FILL: begin
                start_fill(s);
                finish_fill(s);
            end
            default: begin
                start_fill(s);
                run_lsu({s.name, " store"}, 1'b1, side, ~s.data, SIZE_WORD, 1'b0, got);
                run_lsu({s.name, " load"}, 1'b0, side, '0, SIZE_WORD, 1'b0, got);
                check_word({s.name, " load"}, ~s.data, got);
                finish_fill(s);
            end
        endcase
    endtask

    initial begin
        logic [31:0]           got;
        logic [31:0]           expected;
        logic [ADDR_WIDTH-1:0] addr;
        mem_size_t             size;
        logic                  sx;
        int                    n;
        lsu_start     = 1'b0;
        lsu_cmd       = '0;
        fill_start    = 1'b0;
        fill_cmd      = '0;
        debug_addr    = '0;
        fail_reported = 1'b0;
        run_passed    = 1'b0;
        foreach (model[i]) model[i] = 8'h00;
        void'($urandom(32'h3172));

        add_step("reset load",     OP_LOAD,    12'h100, 32'h0,        SIZE_WORD,   1'b0, 32'h0);
        add_step("reset load 2",   OP_LOAD,    12'h300, 32'h0,        SIZE_WORD,   1'b0, 32'h0);
        add_step("reset debug",    OP_DEBUG,   12'h100, 32'h0,        SIZE_WORD,   1'b0, 32'h0);
        add_step("word store",     OP_STORE,   12'h100, 32'h8899AABB, SIZE_WORD,   1'b0, 32'h0);
        add_step("word load",      OP_LOAD,    12'h100, 32'h0,        SIZE_WORD,   1'b0, 32'h8899AABB);
        add_step("debug shift",    OP_DEBUG,   12'h101, 32'h0,        SIZE_WORD,   1'b0, 32'h008899AA);
        add_step("byte store",     OP_STORE,   12'h100, 32'h11223384, SIZE_BYTE,   1'b0, 32'h0);
        add_step("byte debug",     OP_DEBUG,   12'h100, 32'h0,        SIZE_WORD,   1'b0, 32'h8899AA84);
        add_step("byte load sx",   OP_LOAD,    12'h100, 32'h0,        SIZE_BYTE,   1'b1, 32'hFFFFFF84);
        add_step("byte load zx",   OP_LOAD,    12'h100, 32'h0,        SIZE_BYTE,   1'b0, 32'h00000084);
        add_step("half store",     OP_STORE,   12'h100, 32'hDEAD9234, SIZE_HALF,   1'b0, 32'h0);
        add_step("half debug",     OP_DEBUG,   12'h100, 32'h0,        SIZE_WORD,   1'b0, 32'h88999234);
        add_step("half load sx",   OP_LOAD,    12'h100, 32'h0,        SIZE_HALF,   1'b1, 32'hFFFF9234);
        add_step("half load zx",   OP_LOAD,    12'h100, 32'h0,        SIZE_HALF,   1'b0, 32'h00009234);
        add_step("triple store",   OP_STORE,   12'h100, 32'h55C01234, SIZE_TRIPLE, 1'b0, 32'h0);
        add_step("triple debug",   OP_DEBUG,   12'h100, 32'h0,        SIZE_WORD,   1'b0, 32'h88C01234);
        add_step("triple load sx", OP_LOAD,    12'h100, 32'h0,        SIZE_TRIPLE, 1'b1, 32'hFFC01234);
        add_step("triple load zx", OP_LOAD,    12'h100, 32'h0,        SIZE_TRIPLE, 1'b0, 32'h00C01234);
        add_step("wrap store",     OP_STORE,   12'hFFE, 32'h01020304, SIZE_WORD,   1'b0, 32'h0);
        add_step("wrap debug",     OP_DEBUG,   12'h000, 32'h0,        SIZE_WORD,   1'b0, 32'h00000102);
        add_step("wrap load",      OP_LOAD,    12'hFFE, 32'h0,        SIZE_WORD,   1'b0, 32'h01020304);
        add_step("fill",           OP_FILL,    12'h300, 32'hA5A50000, SIZE_WORD,   1'b0, 32'd6);
        add_step("fill with lsu",  OP_FILL_LS, 12'h400, 32'h10000000, SIZE_WORD,   1'b0, 32'd24);

        for (n = 0; n < TIMEOUT; n++) begin
            @(negedge clk);
            if (!rst) break;
        end
        if (n == TIMEOUT) begin
            $display("Reset was never released");
            stop_on_error();
        end
        check_done("reset lsu_done", 1'b0, lsu_done);
        check_done("reset fill_busy", 1'b0, fill_busy);
        check_done("reset fill_done", 1'b0, fill_done);

        foreach (steps[i]) apply_step(steps[i]);

        // Random sized traffic in a small window so loads see earlier stores
        for (int r = 0; r < 50; r++) begin
            addr = ADDR_WIDTH'(12'h500) + ADDR_WIDTH'($urandom % 16);
            size = mem_size_t'(2'($urandom));
            run_lsu($sformatf("random store %0d", r), 1'b1, addr, $urandom, size, 1'b0, got);
            addr     = ADDR_WIDTH'(12'h500) + ADDR_WIDTH'($urandom % 16);
            size     = mem_size_t'(2'($urandom));
            sx       = 1'($urandom);
            expected = model_load(addr, size, sx);
            run_lsu($sformatf("random load %0d", r), 1'b0, addr, '0, size, sx, got);
            check_word($sformatf("random load %0d", r), expected, got);
        end

        run_passed = 1'b1;
        $display("Testbench passed");
        $finish;
    end

    final begin
        if (!run_passed && !fail_reported) begin
            $display("Testbench failed");  // Stopped by an assertion
        end
    end

endmodule

/* compile.f */
mem_pkg.sv
data_memory.sv
mem_arbiter.sv
load_store_port.sv
block_fill.sv
mem_subsys_top.sv
tb_clock_gen.sv
mem_subsys_asserts.sv
mem_subsys_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module mem_subsys_tb -f compile.f \
    && ./obj_dir/Vmem_subsys_tb 2>&1 | tee sim.log
grep -qx "Testbench passed" sim.log && echo "Simulation PASS" || { echo "Simulation FAIL"; exit 1; }
